//--- decode_pkg.sv
package decode_pkg;

    // ------------------------------------------------------------
    // basic types
    // ------------------------------------------------------------
    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_addr_t;

    localparam xlen_t RESET_PC = 32'h1c00_0000;

    // one-hot bit positions
    typedef logic [11:0] alu_op_t;
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    typedef logic [7:0] mem_op_t;
    localparam int MEM_LD_B  = 0;
    localparam int MEM_LD_H  = 1;
    localparam int MEM_LD_W  = 2;
    localparam int MEM_LD_BU = 3;
    localparam int MEM_LD_HU = 4;
    localparam int MEM_ST_B  = 5;
    localparam int MEM_ST_H  = 6;
    localparam int MEM_ST_W  = 7;

    typedef enum logic [3:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU, BR_B, BR_BL, BR_JIRL
    } br_kind_t;

    // ------------------------------------------------------------
    // opcode fields
    // ------------------------------------------------------------
    localparam logic [5:0] OP_GRP0      = 6'h00;
    localparam logic [5:0] OP_LU12I     = 6'h05;
    localparam logic [5:0] OP_PCADDU12I = 6'h07;
    localparam logic [5:0] OP_MEM       = 6'h0a;
    localparam logic [5:0] OP_JIRL      = 6'h13;
    localparam logic [5:0] OP_B         = 6'h14;
    localparam logic [5:0] OP_BL        = 6'h15;
    localparam logic [5:0] OP_BEQ       = 6'h16;
    localparam logic [5:0] OP_BNE       = 6'h17;
    localparam logic [5:0] OP_BLT       = 6'h18;
    localparam logic [5:0] OP_BGE       = 6'h19;
    localparam logic [5:0] OP_BLTU      = 6'h1a;
    localparam logic [5:0] OP_BGEU      = 6'h1b;

    // minor opcode, group 0
    localparam logic [3:0] MIN_3R      = 4'h0;
    localparam logic [3:0] MIN_SHIFT_I = 4'h1;
    localparam logic [3:0] MIN_SLTI    = 4'h8;
    localparam logic [3:0] MIN_SLTUI   = 4'h9;
    localparam logic [3:0] MIN_ADDI    = 4'ha;
    localparam logic [3:0] MIN_ANDI    = 4'hd;
    localparam logic [3:0] MIN_ORI     = 4'he;
    localparam logic [3:0] MIN_XORI    = 4'hf;

    // minor opcode, load/store group
    localparam logic [3:0] MIN_LD_B  = 4'h0;
    localparam logic [3:0] MIN_LD_H  = 4'h1;
    localparam logic [3:0] MIN_LD_W  = 4'h2;
    localparam logic [3:0] MIN_ST_B  = 4'h4;
    localparam logic [3:0] MIN_ST_H  = 4'h5;
    localparam logic [3:0] MIN_ST_W  = 4'h6;
    localparam logic [3:0] MIN_LD_BU = 4'h8;
    localparam logic [3:0] MIN_LD_HU = 4'h9;

    // inst[21:20] selects the 3R or shift-immediate space
    localparam logic [1:0] SUB_3R      = 2'b01;
    localparam logic [1:0] SUB_SHIFT_I = 2'b00;

    localparam logic [4:0] FN_ADD  = 5'h00;
    localparam logic [4:0] FN_SUB  = 5'h02;
    localparam logic [4:0] FN_SLT  = 5'h04;
    localparam logic [4:0] FN_SLTU = 5'h05;
    localparam logic [4:0] FN_NOR  = 5'h08;
    localparam logic [4:0] FN_AND  = 5'h09;
    localparam logic [4:0] FN_OR   = 5'h0a;
    localparam logic [4:0] FN_XOR  = 5'h0b;
    localparam logic [4:0] FN_SLL  = 5'h0e;
    localparam logic [4:0] FN_SRL  = 5'h0f;
    localparam logic [4:0] FN_SRA  = 5'h10;
    localparam logic [4:0] FN_SLLI = 5'h01;
    localparam logic [4:0] FN_SRLI = 5'h09;
    localparam logic [4:0] FN_SRAI = 5'h11;

    // ------------------------------------------------------------
    // instruction word and bundles
    // ------------------------------------------------------------
    typedef struct packed {
        logic [5:0] op_hi;
        logic [3:0] op_mid;
        logic [6:0] op_lo;
        reg_addr_t  rk;
        reg_addr_t  rj;
        reg_addr_t  rd;
    } inst_reg_t;

    typedef struct packed {
        logic [5:0]  op_hi;
        logic [15:0] imm;
        reg_addr_t   rj;
        reg_addr_t   rd;
    } inst_imm_t;

    typedef union packed {
        inst_reg_t r;
        inst_imm_t i;
    } inst_word_u;

    typedef struct packed {
        alu_op_t   alu_op;
        mem_op_t   mem_op;
        logic      src1_is_pc;
        logic      src2_is_imm;
        logic      gr_we;
        logic      mem_we;
        logic      res_from_mem;
        reg_addr_t dest;
        xlen_t     imm;
    } dec_ctrl_t;

    typedef struct packed {
        logic      valid;
        logic      gr_we;
        logic      res_from_mem;
        reg_addr_t dest;
        xlen_t     value;
    } byp_src_t;

    typedef struct packed {
        dec_ctrl_t ctrl;
        xlen_t     pc;
        xlen_t     rj_value;
        xlen_t     rkd_value;
    } id_ex_t;

endpackage

//--- inst_decoder.sv
`timescale 1ns/100ps

module inst_decoder
    import decode_pkg::*;
(
    input  inst_word_u inst,
    output dec_ctrl_t  ctrl,
    output br_kind_t   br_kind,
    output reg_addr_t  raddr1,
    output reg_addr_t  raddr2
);

    alu_op_t     alu;
    mem_op_t     mem;
    logic        need_ui5;
    logic        need_si12;
    logic        need_ui12;
    logic        need_si20;
    logic        link;
    logic        pc_rel;
    logic        hit;
    logic        src_is_rd;
    logic [11:0] i12;
    logic [19:0] i20;

    assign i12 = inst.i.imm[11:0];
    assign i20 = {inst.i.imm[14:0], inst.i.rj};

    always_comb begin
        alu       = '0;
        mem       = '0;
        need_ui5  = 1'b0;
        need_si12 = 1'b0;
        need_ui12 = 1'b0;
        need_si20 = 1'b0;
        link      = 1'b0;
        pc_rel    = 1'b0;
        br_kind   = BR_NONE;
        case (inst.r.op_hi)
            OP_GRP0: begin
                case (inst.r.op_mid)
                    MIN_3R: begin
                        if (inst.r.op_lo[6:5] == SUB_3R) begin
                            case (inst.r.op_lo[4:0])
                                FN_ADD:  alu[ALU_ADD]  = 1'b1;
                                FN_SUB:  alu[ALU_SUB]  = 1'b1;
                                FN_SLT:  alu[ALU_SLT]  = 1'b1;
                                FN_SLTU: alu[ALU_SLTU] = 1'b1;
                                FN_NOR:  alu[ALU_NOR]  = 1'b1;
                                FN_AND:  alu[ALU_AND]  = 1'b1;
                                FN_OR:   alu[ALU_OR]   = 1'b1;
                                FN_XOR:  alu[ALU_XOR]  = 1'b1;
                                FN_SLL:  alu[ALU_SLL]  = 1'b1;
                                FN_SRL:  alu[ALU_SRL]  = 1'b1;
                                FN_SRA:  alu[ALU_SRA]  = 1'b1;
                                default: alu = '0;
                            endcase
                        end
                    end
                    MIN_SHIFT_I: begin
                        need_ui5 = 1'b1;
                        if (inst.r.op_lo[6:5] == SUB_SHIFT_I) begin
                            case (inst.r.op_lo[4:0])
                                FN_SLLI: alu[ALU_SLL] = 1'b1;
                                FN_SRLI: alu[ALU_SRL] = 1'b1;
                                FN_SRAI: alu[ALU_SRA] = 1'b1;
                                default: alu = '0;
                            endcase
                        end
                    end
                    MIN_SLTI:  {alu[ALU_SLT], need_si12}  = 2'b11;
                    MIN_SLTUI: {alu[ALU_SLTU], need_si12} = 2'b11;
                    MIN_ADDI:  {alu[ALU_ADD], need_si12}  = 2'b11;
                    MIN_ANDI:  {alu[ALU_AND], need_ui12}  = 2'b11;
                    MIN_ORI:   {alu[ALU_OR], need_ui12}   = 2'b11;
                    MIN_XORI:  {alu[ALU_XOR], need_ui12}  = 2'b11;
                    default:   alu = '0;
                endcase
            end
            OP_LU12I: begin
                // inst[25] set is another encoding
                if (!inst.i.imm[15]) begin
                    alu[ALU_LUI] = 1'b1;
                    need_si20    = 1'b1;
                end
            end
            OP_PCADDU12I: begin
                alu[ALU_ADD] = 1'b1;
                need_si20    = 1'b1;
                pc_rel       = 1'b1;
            end
            OP_MEM: begin
                // address is rj + si12 for the whole group
                alu[ALU_ADD] = 1'b1;
                need_si12    = 1'b1;
                case (inst.r.op_mid)
                    MIN_LD_B:  mem[MEM_LD_B]  = 1'b1;
                    MIN_LD_H:  mem[MEM_LD_H]  = 1'b1;
                    MIN_LD_W:  mem[MEM_LD_W]  = 1'b1;
                    MIN_LD_BU: mem[MEM_LD_BU] = 1'b1;
                    MIN_LD_HU: mem[MEM_LD_HU] = 1'b1;
                    MIN_ST_B:  mem[MEM_ST_B]  = 1'b1;
                    MIN_ST_H:  mem[MEM_ST_H]  = 1'b1;
                    MIN_ST_W:  mem[MEM_ST_W]  = 1'b1;
                    default:   alu = '0;
                endcase
            end
            OP_JIRL: begin
                alu[ALU_ADD] = 1'b1;
                link         = 1'b1;
                br_kind      = BR_JIRL;
            end
            OP_BL: begin
                alu[ALU_ADD] = 1'b1;
                link         = 1'b1;
                br_kind      = BR_BL;
            end
            OP_B:    br_kind = BR_B;
            OP_BEQ:  br_kind = BR_BEQ;
            OP_BNE:  br_kind = BR_BNE;
            OP_BLT:  br_kind = BR_BLT;
            OP_BGE:  br_kind = BR_BGE;
            OP_BLTU: br_kind = BR_BLTU;
            OP_BGEU: br_kind = BR_BGEU;
            default: br_kind = BR_NONE;
        endcase
    end

    assign hit       = (|alu) | (|mem) | (br_kind != BR_NONE);
    assign src_is_rd = mem[MEM_ST_B] | mem[MEM_ST_H] | mem[MEM_ST_W]
                     | (br_kind inside {BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU});

    always_comb begin
        ctrl = '0;
        if (hit) begin
            ctrl.alu_op       = alu;
            ctrl.mem_op       = mem;
            ctrl.src1_is_pc   = link | pc_rel;
            ctrl.src2_is_imm  = need_ui5 | need_si12 | need_ui12 | need_si20 | link;
            ctrl.res_from_mem = mem[MEM_LD_B] | mem[MEM_LD_H] | mem[MEM_LD_W]
                              | mem[MEM_LD_BU] | mem[MEM_LD_HU];
            ctrl.mem_we       = mem[MEM_ST_B] | mem[MEM_ST_H] | mem[MEM_ST_W];
            // every writer drives some alu op, stores are the exception
            ctrl.gr_we        = (|alu) & ~ctrl.mem_we;
            ctrl.dest         = (br_kind == BR_BL) ? 5'd1 : inst.r.rd;
            if (link) begin
                ctrl.imm = 32'd4;
            end else if (need_si20) begin
                ctrl.imm = {i20, 12'b0};
            end else if (need_ui12) begin
                ctrl.imm = {20'b0, i12};
            end else if (need_ui5) begin
                ctrl.imm = {27'b0, inst.r.rk};
            end else if (need_si12) begin
                ctrl.imm = {{20{i12[11]}}, i12};
            end
        end
    end

    assign raddr1 = inst.r.rj;
    assign raddr2 = src_is_rd ? inst.r.rd : inst.r.rk;

endmodule

//--- reg_file.sv
`timescale 1ns/100ps

module reg_file
    import decode_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    output xlen_t     rdata1,
    output xlen_t     rdata2,
    input  byp_src_t  wb
);

    // r0 has no storage
    xlen_t regs [1:31];
    logic  we;

    assign we = wb.valid & wb.gr_we & (wb.dest != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wb.dest] <= wb.value;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- operand_bypass.sv
`timescale 1ns/100ps

module operand_bypass
    import decode_pkg::*;
(
    input  logic      in_valid,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    input  logic      use1,
    input  logic      use2,
    input  xlen_t     rdata1,
    input  xlen_t     rdata2,
    input  byp_src_t  ex_byp,
    input  byp_src_t  mem_byp,
    input  byp_src_t  wb_byp,
    output xlen_t     rj_value,
    output xlen_t     rkd_value,
    output logic      stall
);

    // producer writes this register, r0 never matches
    function automatic logic src_hit(byp_src_t s, reg_addr_t a);
        return s.valid && s.gr_we && (s.dest != '0) && (s.dest == a);
    endfunction

    function automatic logic load_hit(byp_src_t s, reg_addr_t a);
        return src_hit(s, a) && s.res_from_mem;
    endfunction

    // EX before MEM before WB, loads in EX/MEM have no value yet
    function automatic xlen_t pick(reg_addr_t a, xlen_t rf, byp_src_t ex,
                                   byp_src_t mem, byp_src_t wb);
        if (src_hit(ex, a) && !ex.res_from_mem) begin
            return ex.value;
        end else if (src_hit(mem, a) && !mem.res_from_mem) begin
            return mem.value;
        end else if (src_hit(wb, a)) begin
            return wb.value;
        end
        return rf;
    endfunction

    assign rj_value  = pick(raddr1, rdata1, ex_byp, mem_byp, wb_byp);
    assign rkd_value = pick(raddr2, rdata2, ex_byp, mem_byp, wb_byp);

    // load-use
    assign stall = in_valid & (
        (use1 & (load_hit(ex_byp, raddr1) | load_hit(mem_byp, raddr1))) |
        (use2 & (load_hit(ex_byp, raddr2) | load_hit(mem_byp, raddr2)))
    );

endmodule

//--- branch_unit.sv
`timescale 1ns/100ps

module branch_unit
    import decode_pkg::*;
(
    input  br_kind_t    br_kind,
    input  xlen_t       pc,
    input  xlen_t       rj_value,
    input  xlen_t       rkd_value,
    input  logic [15:0] offs16,
    input  logic [25:0] offs26,
    output logic        taken,
    output xlen_t       target
);

    logic  eq;
    logic  lt;
    logic  ltu;
    xlen_t offs_s16;
    xlen_t offs_s26;

    assign eq  = (rj_value == rkd_value);
    assign lt  = ($signed(rj_value) < $signed(rkd_value));
    assign ltu = (rj_value < rkd_value);

    // word offsets
    assign offs_s16 = {{14{offs16[15]}}, offs16, 2'b00};
    assign offs_s26 = {{4{offs26[25]}}, offs26, 2'b00};

    always_comb begin
        case (br_kind)
            BR_BEQ:  taken = eq;
            BR_BNE:  taken = ~eq;
            BR_BLT:  taken = lt;
            BR_BGE:  taken = ~lt;
            BR_BLTU: taken = ltu;
            BR_BGEU: taken = ~ltu;
            BR_B, BR_BL, BR_JIRL: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        case (br_kind)
            BR_NONE: target = '0;
            BR_JIRL: target = rj_value + offs_s16;
            BR_B, BR_BL: target = pc + offs_s26;
            default: target = pc + offs_s16;
        endcase
    end

endmodule

//--- decode_stage.sv
`timescale 1ns/100ps

module decode_stage
    import decode_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    input  logic       in_valid,
    output logic       in_ready,
    input  inst_word_u inst,
    input  xlen_t      pc,

    output logic       out_valid,
    input  logic       out_ready,
    output id_ex_t     out,

    input  xlen_t      ex_result,
    input  byp_src_t   mem_byp,
    input  byp_src_t   wb_byp,

    output logic       br_taken,
    output xlen_t      br_target
);

    dec_ctrl_t ctrl;
    br_kind_t  br_kind;
    reg_addr_t raddr1;
    reg_addr_t raddr2;
    xlen_t     rdata1;
    xlen_t     rdata2;
    xlen_t     rj_value;
    xlen_t     rkd_value;
    byp_src_t  ex_byp;
    logic      stall;
    logic      accept;
    logic      taken;
    xlen_t     target;

    // ------------------------------------------------------------
    // decode, register read, forwarding
    // ------------------------------------------------------------
    inst_decoder u_dec (
        .inst    (inst),
        .ctrl    (ctrl),
        .br_kind (br_kind),
        .raddr1  (raddr1),
        .raddr2  (raddr2)
    );

    reg_file u_rf (
        .clk    (clk),
        .rst    (rst),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .wb     (wb_byp)
    );

    // EX stage is whatever sits in our output register
    assign ex_byp = '{valid:        out_valid,
                      gr_we:        out.ctrl.gr_we,
                      res_from_mem: out.ctrl.res_from_mem,
                      dest:         out.ctrl.dest,
                      value:        ex_result};

    operand_bypass u_byp (
        .in_valid  (in_valid),
        .raddr1    (raddr1),
        .raddr2    (raddr2),
        .use1      (~ctrl.src1_is_pc),
        .use2      (~ctrl.src2_is_imm),
        .rdata1    (rdata1),
        .rdata2    (rdata2),
        .ex_byp    (ex_byp),
        .mem_byp   (mem_byp),
        .wb_byp    (wb_byp),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .stall     (stall)
    );

    branch_unit u_br (
        .br_kind   (br_kind),
        .pc        (pc),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .offs16    (inst.i.imm),
        .offs26    ({inst.i.rj, inst.i.rd, inst.i.imm}),
        .taken     (taken),
        .target    (target)
    );

    // ------------------------------------------------------------
    // handshake and output register
    // ------------------------------------------------------------
    assign in_ready = ~rst & (~in_valid | (out_ready & ~stall));
    assign accept   = in_valid & in_ready;

    // redirect only counts in the accept cycle
    assign br_taken  = accept & taken;
    assign br_target = accept ? target : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (out_ready) begin
            out_valid <= in_valid & ~stall;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out <= '{ctrl: '0, pc: RESET_PC, rj_value: '0, rkd_value: '0};
        end else if (accept) begin
            out <= '{ctrl: ctrl, pc: pc, rj_value: rj_value, rkd_value: rkd_value};
        end
    end

endmodule

//--- decode_stage_assert.sv
`timescale 1ns/100ps

module decode_stage_assert
    import decode_pkg::*;
(
    input logic   clk,
    input logic   rst,
    input logic   in_valid,
    input logic   in_ready,
    input xlen_t  pc,
    input logic   out_valid,
    input logic   out_ready,
    input id_ex_t out,
    input logic   br_taken
);

    // stalled output keeps its contents
    property p_out_hold;
        @(posedge clk) disable iff (rst)
            (out_valid && !out_ready) |=> (out_valid && $stable(out));
    endproperty

    property p_valid_after_reset;
        @(posedge clk) $fell(rst) |-> !out_valid;
    endproperty

    // a redirect leaves its branch in the output register
    property p_taken_loads;
        @(posedge clk) disable iff (rst)
            br_taken |=> (out_valid && out.pc == $past(pc));
    endproperty

    a_out_hold: assert property (p_out_hold)
        else $error("output changed while held by out_ready");
    a_valid_after_reset: assert property (p_valid_after_reset)
        else $error("out_valid high right after reset");
    a_taken_loads: assert property (p_taken_loads)
        else $error("taken branch missing from the output register");

endmodule

bind decode_stage decode_stage_assert u_assert (.*);

//--- tb_decode_stage.sv
`timescale 1ns/100ps

module tb_decode_stage
    import decode_pkg::*;
;

    typedef struct packed {
        logic [31:0] kind;
        logic [31:0] inst;
        logic [31:0] pc;
        logic [31:0] ordy;
        logic [31:0] exres;
        logic [31:0] mflg;
        logic [31:0] mdst;
        logic [31:0] mval;
        logic [31:0] wflg;
        logic [31:0] wdst;
        logic [31:0] wval;
        logic [31:0] alu;
        logic [31:0] mem;
        logic [31:0] flg;
        logic [31:0] dest;
        logic [31:0] imm;
        logic [31:0] rj;
        logic [31:0] rkd;
        logic [31:0] tkn;
        logic [31:0] tgt;
        logic [31:0] irdy;
    } case_t;

    logic       clk;
    logic       rst;
    logic       in_valid;
    logic       in_ready;
    inst_word_u inst;
    xlen_t      pc;
    logic       out_valid;
    logic       out_ready;
    id_ex_t     out;
    xlen_t      ex_result;
    byp_src_t   mem_byp;
    byp_src_t   wb_byp;
    logic       br_taken;
    xlen_t      br_target;

    case_t cases [$];
    int    cycles;
    int    limit;

    decode_stage dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------
    task automatic check_ctrl(string name, dec_ctrl_t got, dec_ctrl_t exp);
        if (got !== exp) begin
            $display("FAILED time %0t %s got %h expected %h", $time, name, got, exp);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    task automatic check_word(string name, xlen_t got, xlen_t exp);
        if (got !== exp) begin
            $display("FAILED time %0t %s got %h expected %h", $time, name, got, exp);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("FAILED time %0t %s got %b expected %b", $time, name, got, exp);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    // flag digit is valid, gr_we, res_from_mem
    function automatic byp_src_t make_byp(logic [31:0] flg, logic [31:0] dst,
                                          logic [31:0] val);
        byp_src_t b;
        b.valid        = flg[2];
        b.gr_we        = flg[1];
        b.res_from_mem = flg[0];
        b.dest         = dst[4:0];
        b.value        = val;
        return b;
    endfunction

    function automatic dec_ctrl_t make_ctrl(case_t c);
        dec_ctrl_t d;
        d.alu_op       = c.alu[11:0];
        d.mem_op       = c.mem[7:0];
        d.src1_is_pc   = c.flg[4];
        d.src2_is_imm  = c.flg[3];
        d.gr_we        = c.flg[2];
        d.mem_we       = c.flg[1];
        d.res_from_mem = c.flg[0];
        d.dest         = c.dest[4:0];
        d.imm          = c.imm;
        return d;
    endfunction

    task automatic load_cases();
        int    fd;
        int    n;
        string line;
        case_t c;
        fd = $fopen("decode_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open decode_cases.txt");
            $display("Some tests failed");
            $fatal(1);
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            c.kind, c.inst, c.pc, c.ordy, c.exres, c.mflg, c.mdst, c.mval,
                            c.wflg, c.wdst, c.wval, c.alu, c.mem, c.flg, c.dest, c.imm,
                            c.rj, c.rkd, c.tkn, c.tgt, c.irdy);
                if (n == 21) begin
                    cases.push_back(c);
                end
            end
        end
        $fclose(fd);
    endtask

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("the run did not finish within %0d cycles", limit);
            $display("Some tests failed");
            $fatal(1);
        end
    end

    initial begin
        dec_ctrl_t exp_ctrl;
        xlen_t     exp_pc;
        xlen_t     exp_rj;
        xlen_t     exp_rkd;
        logic      exp_valid;
        case_t     c;
        cycles    = 0;
        limit     = 0;
        rst       = 1'b1;
        in_valid  = 1'b0;
        inst      = '0;
        pc        = '0;
        out_ready = 1'b1;
        ex_result = '0;
        mem_byp   = '0;
        wb_byp    = '0;
        load_cases();
        if (cases.size() == 0) begin
            $display("no cases were read from decode_cases.txt");
            $display("Some tests failed");
            $fatal(1);
        end
        limit = 20 * cases.size() + 50;

        // output register contents after reset
        exp_valid = 1'b0;
        exp_ctrl  = '0;
        exp_pc    = RESET_PC;
        exp_rj    = '0;
        exp_rkd   = '0;

        repeat (3) @(posedge clk);
        #10;
        rst = 1'b0;
        check_bit("out_valid", out_valid, exp_valid);
        check_ctrl("out.ctrl", out.ctrl, exp_ctrl);
        check_word("out.pc", out.pc, exp_pc);

        foreach (cases[i]) begin
            c         = cases[i];
            in_valid  = (c.kind != 0);
            inst      = c.inst;
            pc        = c.pc;
            out_ready = c.ordy[0];
            ex_result = c.exres;
            mem_byp   = make_byp(c.mflg, c.mdst, c.mval);
            wb_byp    = make_byp(c.wflg, c.wdst, c.wval);

            @(negedge clk);
            check_bit("in_ready", in_ready, c.irdy[0]);
            check_bit("br_taken", br_taken, c.tkn[0]);
            check_word("br_target", br_target, c.tgt);

            @(posedge clk);
            #1;
            // kind 3 holds everything, the register only loads on accept
            if (c.kind == 1) begin
                exp_valid = 1'b1;
                exp_ctrl  = make_ctrl(c);
                exp_pc    = c.pc;
                exp_rj    = c.rj;
                exp_rkd   = c.rkd;
            end else if (c.kind != 3) begin
                // bubble or stalled slot
                exp_valid = 1'b0;
            end
            check_bit("out_valid", out_valid, exp_valid);
            check_ctrl("out.ctrl", out.ctrl, exp_ctrl);
            check_word("out.pc", out.pc, exp_pc);
            check_word("out.rj_value", out.rj_value, exp_rj);
            check_word("out.rkd_value", out.rkd_value, exp_rkd);
            #9;
        end

        $display("All tests passed");
        $finish;
    end

endmodule

//--- decode_cases.txt
# kind inst pc out_ready ex_result mem(flg dest val) wb(flg dest val)
# exp: alu mem flg(pc,imm,gr_we,mem_we,rfm) dest imm rj rkd taken target in_ready
0 0 0 1 0 0 0 0 6 1 10 0 0 0 0 0 0 0 0 0 1
0 0 0 1 0 0 0 0 6 2 3 0 0 0 0 0 0 0 0 0 1
0 0 0 1 0 0 0 0 6 3 fffffff0 0 0 0 0 0 0 0 0 0 1
1 00100824 1c000010 1 0 0 0 0 0 0 0 1 0 04 4 0 10 3 0 0 1
1 02bffc25 1c000014 1 0 0 0 0 0 0 0 1 0 0c 5 ffffffff 10 0 0 0 1
1 0343c066 1c000018 1 0 0 0 0 0 0 0 10 0 0c 6 f0 fffffff0 0 0 0 1
1 00408c47 1c00001c 1 0 0 0 0 0 0 0 100 0 0c 7 3 3 fffffff0 0 0 1
1 142468a8 1c000020 1 0 0 0 0 0 0 0 800 0 0c 8 12345000 0 0 0 0 1
1 1c000029 1c000024 1 0 0 0 0 0 0 0 1 0 1c 9 1000 10 0 0 0 1
1 2880202a 1c000028 1 0 0 0 0 0 0 0 1 4 0d a 8 10 0 0 0 1
1 2a00046b 1c00002c 1 0 0 0 0 0 0 0 1 8 0d b 1 fffffff0 10 0 0 1
1 29bff022 1c000030 1 0 0 0 0 0 0 0 1 80 0a 2 fffffffc 10 3 0 0 1
0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1
2 0010094c 1c000034 1 0 7 a 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 0010094c 1c000034 1 0 0 0 0 6 a abcd 1 0 04 c 0 abcd 3 0 0 1
1 00100824 1c000038 1 0 0 0 0 0 0 0 1 0 04 4 0 10 3 0 0 1
1 0015108d 1c00003c 1 eeee 6 4 1234 6 4 5555 40 0 04 d 0 eeee eeee 0 0 1
1 0015888e 1c000040 1 0 6 4 1234 6 4 5555 80 0 04 e 0 1234 3 0 0 1
0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1
1 0011048f 1c000044 1 0 0 0 0 6 4 6666 2 0 04 f 0 6666 10 0 0 1
1 00148410 1c000048 1 0 6 0 8888 6 0 7777 10 0 04 10 0 0 10 0 0 1
1 58001021 1c000100 1 0 0 0 0 0 0 0 0 0 00 1 0 10 10 1 1c000110 1
1 5ffff822 1c000200 1 0 0 0 0 0 0 0 0 0 00 2 0 10 3 1 1c0001f8 1
1 60002061 1c000300 1 0 0 0 0 0 0 0 0 0 00 1 0 fffffff0 10 1 1c000320 1
1 6c002061 1c000400 1 0 0 0 0 0 0 0 0 0 00 1 0 fffffff0 10 1 1c000420 1
1 68002061 1c000500 1 0 0 0 0 0 0 0 0 0 00 1 0 fffffff0 10 0 1c000520 1
1 64000422 1c000600 1 0 0 0 0 0 0 0 0 0 00 2 0 10 3 1 1c000604 1
1 50040000 1c000700 1 0 0 0 0 0 0 0 0 0 00 0 0 0 0 1 1c000b00 1
1 57ffffff 1c000800 1 0 0 0 0 0 0 0 1 0 1c 1 4 0 0 1 1c0007fc 1
1 4c001040 1c000900 1 0 0 0 0 0 0 0 1 0 1c 0 4 3 6666 1 13 1
3 00100824 1c000a00 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 00100824 1c000a00 1 0 0 0 0 0 0 0 1 0 04 4 0 10 3 0 0 1
0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1

//--- build.f
decode_pkg.sv
inst_decoder.sv
reg_file.sv
operand_bypass.sv
branch_unit.sv
decode_stage.sv
decode_stage_assert.sv
tb_decode_stage.sv

//--- Bender.yml
package:
  name: decode_stage

sources:
  - decode_pkg.sv
  - inst_decoder.sv
  - reg_file.sv
  - operand_bypass.sv
  - branch_unit.sv
  - decode_stage.sv
  - target: test
    files:
      - decode_stage_assert.sv
      - tb_decode_stage.sv
